// ==== common/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W     = 32;
    localparam int OFFSET_W   = 5;
    localparam int INDEX_W    = 7;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
    localparam int LINE_WORDS = 8;
    localparam int WORD_IDX_W = 3;
    localparam int NUM_WAYS   = 2;
    localparam int NUM_SETS   = 2 ** INDEX_W;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        FINISH
    } ctrl_state_e;

    // address split: tag | index | word | byte
    function automatic logic [TAG_W-1:0] addr_tag(input logic [ADDR_W-1:0] a);
        return a[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic logic [INDEX_W-1:0] addr_index(input logic [ADDR_W-1:0] a);
        return a[OFFSET_W +: INDEX_W];
    endfunction

    function automatic logic [WORD_IDX_W-1:0] addr_word(input logic [ADDR_W-1:0] a);
        return a[OFFSET_W-1 -: WORD_IDX_W];
    endfunction

    function automatic logic [ADDR_W-1:0] line_addr(input logic [TAG_W-1:0] tag,
                                                    input logic [INDEX_W-1:0] index);
        return {tag, index, {OFFSET_W{1'b0}}};
    endfunction

endpackage

`default_nettype wire

// ==== common/line_store_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface line_store_if;
    import dcache_pkg::*;

    logic [INDEX_W-1:0]                rd_index;
    logic [WORD_IDX_W-1:0]             rd_word;
    logic                              wr_way;
    logic [INDEX_W-1:0]                wr_index;
    logic [WORD_IDX_W-1:0]             wr_word;
    // one byte-enable group per way
    logic [NUM_WAYS-1:0][3:0]          wr_be;
    logic [31:0]                       wr_data;
    logic                              tag_we;
    logic [TAG_W-1:0]                  wr_tag;
    logic [NUM_WAYS-1:0][TAG_W-1:0]    rd_tag;
    logic [NUM_WAYS-1:0][31:0]         rd_data;

    modport cache_ctrl (
        output rd_index, rd_word, wr_way, wr_index, wr_word, wr_be, wr_data, tag_we, wr_tag,
        input  rd_tag, rd_data
    );

    modport line_store (
        input  rd_index, rd_word, wr_way, wr_index, wr_word, wr_be, wr_data, tag_we, wr_tag,
        output rd_tag, rd_data
    );

endinterface

`default_nettype wire

// ==== common/burst_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface burst_if;
    import dcache_pkg::*;

    // controller side
    logic                  start;
    logic                  write;
    logic [ADDR_W-1:0]     line_addr;
    logic [31:0]           wdata;

    // engine side
    logic [WORD_IDX_W-1:0] need_idx;
    logic                  fill;
    logic [WORD_IDX_W-1:0] fill_idx;
    logic [31:0]           fill_data;
    logic                  done;

    modport cache_ctrl (
        output start, write, line_addr, wdata,
        input  need_idx, fill, fill_idx, fill_data, done
    );

    modport burst_engine (
        input  start, write, line_addr, wdata,
        output need_idx, fill, fill_idx, fill_data, done
    );

endinterface

`default_nettype wire

// ==== source/line_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_store (
    input  logic              clk,
    line_store_if.line_store  store
);
    import dcache_pkg::*;

    logic [TAG_W-1:0]                 tag_mem  [NUM_WAYS][NUM_SETS];
    logic [3:0][7:0]                  data_mem [NUM_WAYS][2**(INDEX_W+WORD_IDX_W)];

    logic [INDEX_W+WORD_IDX_W-1:0]    rd_addr;
    logic [INDEX_W+WORD_IDX_W-1:0]    wr_addr;

    // word address within a way
    assign rd_addr = {store.rd_index, store.rd_word};
    assign wr_addr = {store.wr_index, store.wr_word};

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (store.tag_we && store.wr_way == 1'(w)) begin
                tag_mem[w][store.wr_index] <= store.wr_tag;
            end
            for (int b = 0; b < 4; b++) begin
                if (store.wr_be[w][b]) data_mem[w][wr_addr][b] <= store.wr_data[8*b +: 8];
            end
            // registered read, old data on a same-cycle write
            store.rd_tag[w]  <= tag_mem[w][store.rd_index];
            store.rd_data[w] <= data_mem[w][rd_addr];
        end
    end

    a_be_on_sel_way: assert property (@(posedge clk)
        (|store.wr_be) |-> store.wr_be[~store.wr_way] == 4'b0)
        else $error("byte enables active on the unselected way");

endmodule

`default_nettype wire

// ==== source/burst_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_engine (
    input  logic                          clk,
    input  logic                          rst,
    burst_if.burst_engine                 burst,
    output logic                          mem_rd_req,
    output logic                          mem_wr_req,
    output logic [dcache_pkg::ADDR_W-1:0] mem_addr,
    output logic                          mem_wvalid,
    output logic [31:0]                   mem_wdata,
    output logic                          mem_wlast,
    input  logic                          mem_rvalid,
    input  logic [31:0]                   mem_rdata,
    input  logic                          mem_wack
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        BE_IDLE,
        BE_READ,
        BE_WRITE,
        BE_ACK
    } eng_state_e;

    eng_state_e          state;
    // one bit wider so a write can count past the last word
    logic [WORD_IDX_W:0] cnt;
    logic                last_fill;

    assign burst.need_idx  = cnt[WORD_IDX_W-1:0];
    assign burst.fill      = (state == BE_READ) && mem_rvalid;
    assign burst.fill_idx  = cnt[WORD_IDX_W-1:0];
    assign burst.fill_data = mem_rdata;
    assign last_fill       = burst.fill && (cnt == (WORD_IDX_W+1)'(LINE_WORDS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= BE_IDLE;
            cnt        <= '0;
            mem_rd_req <= 1'b0;
            mem_wr_req <= 1'b0;
            mem_wvalid <= 1'b0;
            mem_wlast  <= 1'b0;
            burst.done <= 1'b0;
        end else begin
            mem_rd_req <= 1'b0;
            mem_wr_req <= 1'b0;
            burst.done <= 1'b0;
            case (state)
                BE_IDLE: begin
                    if (burst.start) begin
                        mem_rd_req <= !burst.write;
                        mem_wr_req <= burst.write;
                        // word 0 is already being read this cycle
                        cnt        <= burst.write ? (WORD_IDX_W+1)'(1) : '0;
                        state      <= burst.write ? BE_WRITE : BE_READ;
                    end
                end
                BE_READ: begin
                    if (last_fill) begin
                        cnt        <= '0;
                        burst.done <= 1'b1;
                        state      <= BE_IDLE;
                    end else if (burst.fill) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                BE_WRITE: begin
                    mem_wvalid <= 1'b1;
                    mem_wlast  <= (cnt == (WORD_IDX_W+1)'(LINE_WORDS));
                    if (cnt == (WORD_IDX_W+1)'(LINE_WORDS)) begin
                        cnt   <= '0;
                        state <= BE_ACK;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                BE_ACK: begin
                    mem_wvalid <= 1'b0;
                    mem_wlast  <= 1'b0;
                    if (mem_wack) begin
                        burst.done <= 1'b1;
                        state      <= BE_IDLE;
                    end
                end
                default: state <= BE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == BE_IDLE && burst.start) mem_addr <= burst.line_addr;
        if (state == BE_WRITE) mem_wdata <= burst.wdata;
    end

    a_rvalid_in_read: assert property (@(posedge clk) disable iff (rst)
        mem_rvalid |-> state == BE_READ)
        else $error("read beat without an open read burst");

endmodule

`default_nettype wire

// ==== cache_ctrl/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req,
    input  logic                          wr,
    input  logic [dcache_pkg::ADDR_W-1:0] addr,
    input  logic [3:0]                    be,
    input  logic [31:0]                   wdata,
    output logic                          done,
    output logic [31:0]                   rdata,
    line_store_if.cache_ctrl              store,
    burst_if.cache_ctrl                   burst
);
    import dcache_pkg::*;

    ctrl_state_e           state;

    // latched request
    logic                  req_wr;
    logic [TAG_W-1:0]      req_tag;
    logic [INDEX_W-1:0]    req_index;
    logic [WORD_IDX_W-1:0] req_word;
    logic [3:0]            req_be;
    logic [31:0]           req_wdata;
    logic                  victim;

    logic [NUM_WAYS-1:0]   valid [NUM_SETS];
    logic [NUM_WAYS-1:0]   dirty [NUM_SETS];
    // lru[set] names the way to evict next
    logic                  lru   [NUM_SETS];

    logic [NUM_WAYS-1:0]   way_hit;
    logic                  hit;
    logic                  hit_way;
    logic                  lru_way;
    logic                  victim_dirty;
    logic                  wb_start;
    logic [31:0]           fill_word;

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  en);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (en[b]) res[8*b +: 8] = new_word[8*b +: 8];
        end
        return res;
    endfunction

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid[req_index][w] && (store.rd_tag[w] == req_tag);
        end
    end

    assign hit          = |way_hit;
    assign hit_way      = way_hit[1];
    assign lru_way      = lru[req_index];
    assign victim_dirty = valid[req_index][lru_way] & dirty[req_index][lru_way];
    assign wb_start     = (state == LOOKUP) && !hit && victim_dirty;

    // cpu bytes land on the target word as it streams in
    assign fill_word = (req_wr && burst.fill_idx == req_word) ?
                       merge_bytes(burst.fill_data, req_wdata, req_be) : burst.fill_data;

    // storage access
    always_comb begin
        store.rd_index = (state == IDLE) ? addr_index(addr) : req_index;
        case (state)
            IDLE:              store.rd_word = addr_word(addr);
            LOOKUP, WRITEBACK: store.rd_word = burst.need_idx;
            default:           store.rd_word = req_word;
        endcase

        store.wr_way   = victim;
        store.wr_index = req_index;
        store.wr_word  = burst.fill_idx;
        store.wr_be    = '0;
        store.wr_data  = fill_word;
        store.tag_we   = 1'b0;
        store.wr_tag   = req_tag;

        if (state == LOOKUP && hit && req_wr) begin
            store.wr_way         = hit_way;
            store.wr_word        = req_word;
            store.wr_data        = req_wdata;
            store.wr_be[hit_way] = req_be;
        end else if (state == REFILL && burst.fill) begin
            store.wr_be[victim] = 4'hf;
            store.tag_we        = 1'b1;
        end
    end

    // burst commands
    assign burst.start     = ((state == LOOKUP) && !hit) || ((state == WRITEBACK) && burst.done);
    assign burst.write     = wb_start;
    assign burst.line_addr = wb_start ? line_addr(store.rd_tag[lru_way], req_index)
                                      : line_addr(req_tag, req_index);
    assign burst.wdata     = store.rd_data[victim];

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            done   <= 1'b0;
            victim <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
                lru[s]   <= 1'b0;
            end
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (req) state <= LOOKUP;
                end
                LOOKUP: begin
                    if (hit) begin
                        lru[req_index] <= ~hit_way;
                        if (req_wr) dirty[req_index][hit_way] <= 1'b1;
                        done  <= 1'b1;
                        state <= IDLE;
                    end else begin
                        lru[req_index] <= ~lru_way;
                        victim         <= lru_way;
                        state          <= victim_dirty ? WRITEBACK : REFILL;
                    end
                end
                WRITEBACK: begin
                    if (burst.done) state <= REFILL;
                end
                REFILL: begin
                    if (burst.done) begin
                        valid[req_index][victim] <= 1'b1;
                        dirty[req_index][victim] <= req_wr;
                        state                    <= FINISH;
                    end
                end
                FINISH: begin
                    done  <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            req_wr    <= wr;
            req_tag   <= addr_tag(addr);
            req_index <= addr_index(addr);
            req_word  <= addr_word(addr);
            req_be    <= be;
            req_wdata <= wdata;
        end
        if (state == LOOKUP && hit) rdata <= store.rd_data[hit_way];
        if (state == FINISH) rdata <= store.rd_data[victim];
    end

    // cpu waits for done before the next request
    a_req_in_idle: assert property (@(posedge clk) disable iff (rst) req |-> state == IDLE)
        else $error("request arrived while the cache was busy");

    a_single_hit: assert property (@(posedge clk) disable iff (rst)
        state == LOOKUP |-> !(&way_hit))
        else $error("both ways hit the same tag");

endmodule

`default_nettype wire

// ==== source/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                          clk,
    input  logic                          rst,

    // cpu side
    input  logic                          req,
    input  logic                          wr,
    input  logic [dcache_pkg::ADDR_W-1:0] addr,
    input  logic [3:0]                    be,
    input  logic [31:0]                   wdata,
    output logic                          done,
    output logic [31:0]                   rdata,

    // memory side
    output logic                          mem_rd_req,
    output logic                          mem_wr_req,
    output logic [dcache_pkg::ADDR_W-1:0] mem_addr,
    output logic                          mem_wvalid,
    output logic [31:0]                   mem_wdata,
    output logic                          mem_wlast,
    input  logic                          mem_rvalid,
    input  logic [31:0]                   mem_rdata,
    input  logic                          mem_wack
);

    line_store_if store_bus ();
    burst_if      mem_bus ();

    cache_ctrl i_cache_ctrl (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .wr    (wr),
        .addr  (addr),
        .be    (be),
        .wdata (wdata),
        .done  (done),
        .rdata (rdata),
        .store (store_bus.cache_ctrl),
        .burst (mem_bus.cache_ctrl)
    );

    line_store i_line_store (
        .clk   (clk),
        .store (store_bus.line_store)
    );

    burst_engine i_burst_engine (
        .clk        (clk),
        .rst        (rst),
        .burst      (mem_bus.burst_engine),
        .mem_rd_req (mem_rd_req),
        .mem_wr_req (mem_wr_req),
        .mem_addr   (mem_addr),
        .mem_wvalid (mem_wvalid),
        .mem_wdata  (mem_wdata),
        .mem_wlast  (mem_wlast),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .mem_wack   (mem_wack)
    );

endmodule

`default_nettype wire

// ==== sim/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  logic        clk,
    input  logic        mem_rd_req,
    input  logic        mem_wr_req,
    input  logic [31:0] mem_addr,
    input  logic        mem_wvalid,
    input  logic [31:0] mem_wdata,
    input  logic        mem_wlast,
    output logic        mem_rvalid,
    output logic [31:0] mem_rdata,
    output logic        mem_wack
);
    import dcache_pkg::*;

    logic [7:0]  mem_bytes [logic [31:0]];
    logic [31:0] gap_state;

    // burst log, read by the testbench
    int          rd_bursts;
    int          wr_bursts;
    logic [31:0] last_rd_addr;
    logic [31:0] last_wr_addr;
    int          last_wr_beats;
    logic        last_wlast_ok;

    // preload pattern of a word address
    function automatic logic [31:0] init_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h0001_0003) ^ 32'hc3a5_5a3c;
    endfunction

    function automatic logic [31:0] peek_word(input logic [31:0] a);
        logic [31:0] w;
        w = init_word({a[31:2], 2'b00});
        for (int b = 0; b < 4; b++) begin
            if (mem_bytes.exists({a[31:2], 2'(b)})) w[8*b +: 8] = mem_bytes[{a[31:2], 2'(b)}];
        end
        return w;
    endfunction

    // 0 to 3 idle cycles
    function automatic int next_gap();
        gap_state = gap_state * 32'd1664525 + 32'd1013904223;
        return int'(gap_state[17:16]);
    endfunction

    task automatic serve_read(input logic [31:0] base);
        rd_bursts++;
        last_rd_addr = base;
        for (int k = 0; k < LINE_WORDS; k++) begin
            repeat (next_gap()) @(negedge clk);
            mem_rvalid = 1'b1;
            mem_rdata  = peek_word(base + 32'(4 * k));
            @(negedge clk);
            mem_rvalid = 1'b0;
        end
    endtask

    task automatic serve_write(input logic [31:0] base);
        int   beats;
        logic last_seen;
        beats     = 0;
        last_seen = 1'b0;
        wr_bursts++;
        last_wr_addr = base;
        while (!last_seen && beats < LINE_WORDS) begin
            @(negedge clk);
            if (mem_wvalid) begin
                for (int b = 0; b < 4; b++) begin
                    mem_bytes[base + 32'(4 * beats + b)] = mem_wdata[8*b +: 8];
                end
                beats++;
                last_seen = mem_wlast;
            end
        end
        last_wr_beats = beats;
        last_wlast_ok = last_seen && (beats == LINE_WORDS);
        repeat (next_gap()) @(negedge clk);
        mem_wack = 1'b1;
        @(negedge clk);
        mem_wack = 1'b0;
    endtask

    initial begin
        mem_rvalid    = 1'b0;
        mem_rdata     = '0;
        mem_wack      = 1'b0;
        rd_bursts     = 0;
        wr_bursts     = 0;
        last_rd_addr  = '0;
        last_wr_addr  = '0;
        last_wr_beats = 0;
        last_wlast_ok = 1'b0;
        gap_state     = 32'h484;
        // requests are sampled mid-cycle
        forever begin
            @(negedge clk);
            if (mem_rd_req === 1'b1) begin
                serve_read(mem_addr);
            end else if (mem_wr_req === 1'b1) begin
                serve_write(mem_addr);
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int RAND_OPS        = 300;
    localparam int NUM_ACCESSES    = 6 + RAND_OPS;
    localparam int WATCHDOG_CYCLES = 16 + 200 * NUM_ACCESSES;
    localparam logic [TAG_W-1:0]   TAG_A = 20'h00012;
    localparam logic [TAG_W-1:0]   TAG_B = 20'h00034;
    localparam logic [TAG_W-1:0]   TAG_C = 20'h00056;
    localparam logic [INDEX_W-1:0] SET   = 7'd5;

    logic        clk;
    logic        rst;
    logic        req;
    logic        wr;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic        done;
    logic [31:0] rdata;
    logic        mem_rd_req;
    logic        mem_wr_req;
    logic [31:0] mem_addr;
    logic        mem_wvalid;
    logic [31:0] mem_wdata;
    logic        mem_wlast;
    logic        mem_rvalid;
    logic [31:0] mem_rdata;
    logic        mem_wack;

    int          errors;
    int          tests_run;
    int          tests_failed;
    logic [31:0] rnd_state;
    // bytes written by the cpu, the rest still holds the preload pattern
    logic [7:0]  ref_mem [logic [31:0]];

    dcache_top i_dcache_top (.*);
    mem_model  i_mem (.*);

    function automatic logic [31:0] lcg_next();
        rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
        return rnd_state;
    endfunction

    function automatic logic [31:0] pattern_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h0001_0003) ^ 32'hc3a5_5a3c;
    endfunction

    function automatic logic [31:0] mk_addr(input logic [TAG_W-1:0] tag,
                                           input logic [INDEX_W-1:0] index,
                                           input logic [WORD_IDX_W-1:0] word);
        return {tag, index, word, 2'b00};
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] a);
        logic [31:0] w;
        w = pattern_word({a[31:2], 2'b00});
        for (int b = 0; b < 4; b++) begin
            if (ref_mem.exists({a[31:2], 2'(b)})) w[8*b +: 8] = ref_mem[{a[31:2], 2'(b)}];
        end
        return w;
    endfunction

    task automatic ref_write(input logic [31:0] a, input logic [3:0] en, input logic [31:0] d);
        for (int b = 0; b < 4; b++) begin
            if (en[b]) ref_mem[{a[31:2], 2'(b)}] = d[8*b +: 8];
        end
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d checks failed", name, errors - errs_before);
        end
    endtask

    // one request, returns read data and cycles until done
    task automatic cpu_access(input logic is_wr, input logic [31:0] a, input logic [3:0] en,
                              input logic [31:0] d, output logic [31:0] got, output int lat);
        @(negedge clk);
        req   = 1'b1;
        wr    = is_wr;
        addr  = a;
        be    = en;
        wdata = d;
        @(negedge clk);
        req = 1'b0;
        lat = 1;
        while (done !== 1'b1) begin
            @(negedge clk);
            lat++;
        end
        got = rdata;
    endtask

    task automatic cold_read_miss();
        int          errs0;
        int          rd0;
        int          lat;
        logic [31:0] got;
        errs0 = errors;
        rd0   = i_mem.rd_bursts;
        cpu_access(1'b0, mk_addr(TAG_A, SET, 3'd3), 4'h0, 32'h0, got, lat);
        check_eq(got, ref_read(mk_addr(TAG_A, SET, 3'd3)), "cold miss data");
        check_eq(32'(i_mem.rd_bursts - rd0), 32'd1, "cold miss read bursts");
        check_eq(i_mem.last_rd_addr, mk_addr(TAG_A, SET, 3'd0), "cold miss burst address");
        report_test("cold_read_miss", errs0);
    endtask

    task automatic read_hit_latency();
        int          errs0;
        int          rd0;
        int          wr0;
        int          lat;
        logic [31:0] got;
        errs0 = errors;
        rd0   = i_mem.rd_bursts;
        wr0   = i_mem.wr_bursts;
        cpu_access(1'b0, mk_addr(TAG_A, SET, 3'd6), 4'h0, 32'h0, got, lat);
        check_eq(got, ref_read(mk_addr(TAG_A, SET, 3'd6)), "hit data");
        check_eq(32'(lat), 32'd2, "hit latency in cycles");
        check_eq(32'(i_mem.rd_bursts - rd0), 32'd0, "read bursts on a hit");
        check_eq(32'(i_mem.wr_bursts - wr0), 32'd0, "write bursts on a hit");
        report_test("read_hit_latency", errs0);
    endtask

    task automatic partial_write_hit();
        int          errs0;
        int          lat;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] got;
        errs0 = errors;
        a     = mk_addr(TAG_A, SET, 3'd3);
        d     = lcg_next();
        cpu_access(1'b1, a, 4'b0101, d, got, lat);
        ref_write(a, 4'b0101, d);
        cpu_access(1'b0, a, 4'h0, 32'h0, got, lat);
        check_eq(got, ref_read(a), "merged word after write hit");
        check_eq(i_mem.peek_word(a), pattern_word(a), "memory before writeback");
        report_test("partial_write_hit", errs0);
    endtask

    // set 5 holds the dirty line of TAG_A, two more tags push it out
    task automatic dirty_eviction();
        int          errs0;
        int          wr0;
        int          lat;
        logic [31:0] got;
        errs0 = errors;
        wr0   = i_mem.wr_bursts;
        cpu_access(1'b0, mk_addr(TAG_B, SET, 3'd0), 4'h0, 32'h0, got, lat);
        check_eq(got, ref_read(mk_addr(TAG_B, SET, 3'd0)), "second tag data");
        check_eq(32'(i_mem.wr_bursts - wr0), 32'd0, "no writeback for an empty way");
        cpu_access(1'b0, mk_addr(TAG_C, SET, 3'd1), 4'h0, 32'h0, got, lat);
        check_eq(got, ref_read(mk_addr(TAG_C, SET, 3'd1)), "third tag data");
        check_eq(32'(i_mem.wr_bursts - wr0), 32'd1, "writeback bursts");
        check_eq(i_mem.last_wr_addr, mk_addr(TAG_A, SET, 3'd0), "writeback address");
        check_eq(32'(i_mem.last_wr_beats), 32'd8, "writeback beats");
        check_eq(32'(i_mem.last_wlast_ok), 32'd1, "mem_wlast on the eighth beat");
        for (int k = 0; k < LINE_WORDS; k++) begin
            check_eq(i_mem.peek_word(mk_addr(TAG_A, SET, 3'(k))),
                     ref_read(mk_addr(TAG_A, SET, 3'(k))), "written back word");
        end
        report_test("dirty_eviction", errs0);
    endtask

    // sets 0, 1, 64, 65 with eight tags each
    task automatic random_traffic();
        int          errs0;
        int          lat;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] got;
        errs0 = errors;
        for (int n = 0; n < RAND_OPS; n++) begin
            r = lcg_next();
            d = lcg_next();
            a = mk_addr(20'h00010 + 20'(r[6:4]), {r[3], 5'b0, r[2]}, r[9:7]);
            if (r[14]) begin
                cpu_access(1'b1, a, r[13:10], d, got, lat);
                ref_write(a, r[13:10], d);
            end else begin
                cpu_access(1'b0, a, 4'h0, 32'h0, got, lat);
                check_eq(got, ref_read(a), $sformatf("random read of %h", a));
            end
        end
        report_test("random_traffic", errs0);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        req          = 1'b0;
        wr           = 1'b0;
        addr         = '0;
        be           = '0;
        wdata        = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rnd_state    = 32'h484;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        cold_read_miss();
        read_hit_latency();
        partial_write_hit();
        dirty_eviction();
        random_traffic();
        $display("%0d tests run, %0d failed, %0d failed checks", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
common/dcache_pkg.sv
common/line_store_if.sv
common/burst_if.sv
source/line_store.sv
source/burst_engine.sv
cache_ctrl/cache_ctrl.sv
source/dcache_top.sv
sim/mem_model.sv
sim/tb_dcache.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   := project.f
TOP        := tb_dcache
RTL_TOP    := dcache_top
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed!
FLAGS      := --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
